// File: src/lv_pkg.sv
/*
 * lv watchdog shared definitions
 * widths, threshold tables, scan list and the structs passed between blocks
 */
`default_nettype none

package lv_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int REG_AW    = 7;
    localparam int REG_DW    = 8;
    localparam int REG_CRC_W = 8;
    localparam int REG_NUM   = 128;
    localparam int WDG_CNT_W = 16;

    // ==============================
    // scan list
    // ==============================
    localparam int LV_SCAN_REG_NUM = 6;
    localparam int SCAN_PTR_W      = $clog2(LV_SCAN_REG_NUM);

    // entry 0 is read first
    localparam logic [LV_SCAN_REG_NUM-1:0][REG_AW-1:0] SCAN_REG_ADDR =
        {7'h30, 7'h0B, 7'h09, 7'h03, 7'h02, 7'h01};

    // ==============================
    // threshold tables
    // ==============================
    // idle cycles between two scan reads
    localparam logic [3:0][WDG_CNT_W-1:0] WDG_SCANREG_TH = {16'd64, 16'd32, 16'd16, 16'd8};
    // idle cycles between two refresh frames
    localparam logic [3:0][WDG_CNT_W-1:0] WDG_REFRESH_TH = {16'd160, 16'd80, 16'd40, 16'd20};
    // response window of the owt receiver
    localparam logic [3:0][WDG_CNT_W-1:0] WDG_TIMEOUT_TH = {16'd80, 16'd40, 16'd20, 16'd10};

    // crc-8, x^8 + x^2 + x + 1
    localparam logic [REG_CRC_W-1:0] CRC_POLY = 8'h07;
    localparam logic [REG_CRC_W-1:0] CRC_INIT = 8'h00;

    // ==============================
    // structs
    // ==============================
    typedef struct packed {
        logic [1:0] tmo;
        logic [1:0] refresh;
        logic [1:0] crc;
    } wdg_cfg_t;

    // single-cycle host write strobe
    typedef struct packed {
        logic                 en;
        logic [REG_AW-1:0]    addr;
        logic [REG_DW-1:0]    data;
        logic [REG_CRC_W-1:0] crc;
    } reg_wr_t;

    typedef struct packed {
        logic                 ack;
        logic [REG_DW-1:0]    data;
        logic [REG_CRC_W-1:0] crc;
    } rac_rsp_t;

endpackage

`default_nettype wire

// File: src/lv_crc8.sv
/*
 * lv crc-8 compressor
 * combinational crc over the tagged 16-bit address/data word, msb first
 */
`timescale 1ns/1ps
`default_nettype none

module lv_crc8 (
    input  wire logic [15:0]                   i_data,
    output logic      [lv_pkg::REG_CRC_W-1:0]  o_crc
);

    logic [lv_pkg::REG_CRC_W-1:0] crc;

    // one shift per input bit, the loop unrolls into a xor tree
    always_comb begin
        logic fb;
        crc = lv_pkg::CRC_INIT;
        for (int i = 15; i >= 0; i--) begin
            fb  = crc[lv_pkg::REG_CRC_W-1] ^ i_data[i];
            crc = {crc[lv_pkg::REG_CRC_W-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ lv_pkg::CRC_POLY;
            end
        end
    end

    assign o_crc = crc;

endmodule

`default_nettype wire

// File: src/lv_reg_access_ctrl.sv
/*
 * lv register access controller
 * register bank with one stored crc per address, host write and watchdog read
 */
`timescale 1ns/1ps
`default_nettype none

module lv_reg_access_ctrl (
    input  wire logic                         i_clk,
    input  wire logic                         i_rst_n,
    input  wire lv_pkg::reg_wr_t              i_wr,
    input  wire logic                         i_rd_req,
    input  wire logic [lv_pkg::REG_AW-1:0]    i_rd_addr,
    output lv_pkg::rac_rsp_t                  o_rsp
);

    // ==============================
    // register bank
    // ==============================
    logic [lv_pkg::REG_DW-1:0]    mem_data [lv_pkg::REG_NUM];
    logic [lv_pkg::REG_CRC_W-1:0] mem_crc  [lv_pkg::REG_NUM];

    // read channel state
    logic rd_req_q;
    logic rd_new;

    // crc is stored as sent by the host
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < lv_pkg::REG_NUM; i++) begin
                mem_data[i] <= '0;
                mem_crc[i]  <= '0;
            end
        end else if (i_wr.en) begin
            mem_data[i_wr.addr] <= i_wr.data;
            mem_crc[i_wr.addr]  <= i_wr.crc;
        end
    end

    // ==============================
    // read response
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_req_q <= 1'b0;
        end else begin
            rd_req_q <= i_rd_req;
        end
    end

    // only the first cycle of a request level is answered
    assign rd_new = i_rd_req & ~rd_req_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rsp.ack <= 1'b0;
        end else begin
            o_rsp.ack <= rd_new;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rsp.data <= '0;
            o_rsp.crc  <= '0;
        end else if (rd_new) begin
            o_rsp.data <= mem_data[i_rd_addr];
            o_rsp.crc  <= mem_crc[i_rd_addr];
        end
    end

    // ==============================
    // assertions
    // ==============================
    // no ack without a request the cycle before
    ack_after_req_a: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_rsp.ack) |-> $past(i_rd_req)
    );

endmodule

`default_nettype wire

// File: src/lv_wdg_ctrl.sv
/*
 * lv watchdog controller
 * scans the configuration registers against their crc and supervises the owt link
 */
`timescale 1ns/1ps
`default_nettype none

module lv_wdg_ctrl (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire lv_pkg::wdg_cfg_t              i_cfg,

    input  wire logic                          i_wdg_scan_en,
    output logic                               o_rd_req,
    output logic      [lv_pkg::REG_AW-1:0]     o_rd_addr,
    input  wire lv_pkg::rac_rsp_t              i_rsp,
    output logic                               o_scan_crc_err,

    input  wire logic                          i_bist_scan_req,
    output logic                               o_bist_ack,
    output logic                               o_bist_err,

    input  wire logic                          i_wdg_owt_en,
    output logic                               o_owt_adc_req,
    input  wire logic                          i_owt_adc_ack,
    input  wire logic                          i_spi_rst_wdg,

    input  wire logic                          i_fsm_owt_tx_req,
    input  wire logic                          i_bist_owt_tx_req,

    input  wire logic                          i_owt_rx_rsp,
    output logic                               o_owt_rx_tmo,
    output logic                               o_wdg_timeout_err
);

    // scan side
    logic [lv_pkg::WDG_CNT_W-1:0]   scan_cnt;
    logic                           scan_hit;
    logic [lv_pkg::SCAN_PTR_W-1:0]  scan_ptr;
    logic                           bist_scan_req_q;
    logic                           bist_launch;
    logic                           rd_launch;
    logic [15:0]                    crc_in;
    logic [lv_pkg::REG_CRC_W-1:0]   crc_calc;

    // owt side
    logic [lv_pkg::WDG_CNT_W-1:0]   refresh_cnt;
    logic                           refresh_hit;
    logic [lv_pkg::WDG_CNT_W-1:0]   tmo_cnt;
    logic                           tmo_hit;
    logic                           fsm_tx_req_q;
    logic                           bist_tx_req_q;
    logic                           owt_launch;
    logic                           adc_req_q;
    logic                           in_flight;

    // ==============================
    // register scan
    // ==============================
    assign scan_hit = (scan_cnt == lv_pkg::WDG_SCANREG_TH[i_cfg.crc] - lv_pkg::WDG_CNT_W'(1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bist_scan_req_q <= 1'b0;
        end else begin
            bist_scan_req_q <= i_bist_scan_req;
        end
    end

    assign bist_launch = i_bist_scan_req & ~bist_scan_req_q;
    assign rd_launch   = scan_hit | bist_launch;

    // period counter holds while a read is outstanding
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scan_cnt <= '0;
        end else if (!i_wdg_scan_en || o_rd_req || i_rsp.ack || scan_hit) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scan_ptr  <= '0;
            o_rd_addr <= '0;
        end else if (rd_launch) begin
            o_rd_addr <= lv_pkg::SCAN_REG_ADDR[scan_ptr];
            if (scan_ptr == lv_pkg::SCAN_PTR_W'(lv_pkg::LV_SCAN_REG_NUM - 1)) begin
                scan_ptr <= '0;
            end else begin
                scan_ptr <= scan_ptr + 1'b1;
            end
        end
    end

    // request level, dropped on the ack
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd_req <= 1'b0;
        end else if (!i_wdg_scan_en && !i_bist_scan_req) begin
            o_rd_req <= 1'b0;
        end else if (i_rsp.ack) begin
            o_rd_req <= 1'b0;
        end else if (rd_launch) begin
            o_rd_req <= 1'b1;
        end
    end

    // address is still held from the launch
    assign crc_in = {1'b1, o_rd_addr, i_rsp.data};

    lv_crc8 crc_i (
        .i_data (crc_in),
        .o_crc  (crc_calc)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_scan_crc_err <= 1'b0;
            o_bist_ack     <= 1'b0;
        end else begin
            o_scan_crc_err <= i_rsp.ack & (i_rsp.crc != crc_calc);
            o_bist_ack     <= i_rsp.ack;
        end
    end

    assign o_bist_err = o_scan_crc_err;

    // ==============================
    // owt refresh
    // ==============================
    assign refresh_hit =
        (refresh_cnt == lv_pkg::WDG_REFRESH_TH[i_cfg.refresh] - lv_pkg::WDG_CNT_W'(1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fsm_tx_req_q  <= 1'b0;
            bist_tx_req_q <= 1'b0;
            adc_req_q     <= 1'b0;
        end else begin
            fsm_tx_req_q  <= i_fsm_owt_tx_req;
            bist_tx_req_q <= i_bist_owt_tx_req;
            adc_req_q     <= o_owt_adc_req;
        end
    end

    assign owt_launch = (i_fsm_owt_tx_req & ~fsm_tx_req_q) |
                        (i_bist_owt_tx_req & ~bist_tx_req_q);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            refresh_cnt <= '0;
        end else if (!i_wdg_owt_en || o_owt_adc_req || i_owt_adc_ack || i_spi_rst_wdg) begin
            refresh_cnt <= '0;
        end else if (refresh_hit) begin
            refresh_cnt <= '0;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_owt_adc_req <= 1'b0;
        end else if (!i_wdg_owt_en || i_owt_adc_ack) begin
            o_owt_adc_req <= 1'b0;
        end else if (refresh_hit || owt_launch) begin
            o_owt_adc_req <= 1'b1;
        end
    end

    // ==============================
    // response timeout
    // ==============================
    assign tmo_hit = (tmo_cnt == lv_pkg::WDG_TIMEOUT_TH[i_cfg.tmo] - lv_pkg::WDG_CNT_W'(1));

    // armed by a new frame request or an spi kick
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            in_flight <= 1'b0;
        end else if (!i_wdg_owt_en || tmo_hit) begin
            in_flight <= 1'b0;
        end else if ((o_owt_adc_req && !adc_req_q) || i_spi_rst_wdg) begin
            in_flight <= 1'b1;
        end else if (i_owt_rx_rsp) begin
            in_flight <= 1'b0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tmo_cnt <= '0;
        end else if (!in_flight || i_owt_rx_rsp || i_spi_rst_wdg || tmo_hit) begin
            tmo_cnt <= '0;
        end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
        end
    end

    assign o_owt_rx_tmo = tmo_hit;

    // sticky until the receiver answers
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wdg_timeout_err <= 1'b0;
        end else if (i_owt_rx_rsp) begin
            o_wdg_timeout_err <= 1'b0;
        end else if (tmo_hit) begin
            o_wdg_timeout_err <= 1'b1;
        end
    end

    // ==============================
    // assertions
    // ==============================
    rd_req_off_a: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (!i_wdg_scan_en && !i_bist_scan_req) |=> !o_rd_req
    );

    adc_req_off_a: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_wdg_owt_en |=> !o_owt_adc_req
    );

endmodule

`default_nettype wire

// File: src/lv_wdg_top.sv
/*
 * lv watchdog top
 * register access controller and watchdog controller on one read channel
 */
`timescale 1ns/1ps
`default_nettype none

module lv_wdg_top (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire lv_pkg::reg_wr_t               i_wr,
    input  wire lv_pkg::wdg_cfg_t              i_cfg,

    input  wire logic                          i_wdg_scan_en,
    input  wire logic                          i_bist_scan_req,
    output logic      [lv_pkg::REG_AW-1:0]     o_scan_addr,
    output logic                               o_scan_crc_err,
    output logic                               o_bist_ack,
    output logic                               o_bist_err,

    input  wire logic                          i_wdg_owt_en,
    output logic                               o_owt_adc_req,
    input  wire logic                          i_owt_adc_ack,
    input  wire logic                          i_spi_rst_wdg,
    input  wire logic                          i_fsm_owt_tx_req,
    input  wire logic                          i_bist_owt_tx_req,
    input  wire logic                          i_owt_rx_rsp,
    output logic                               o_owt_rx_tmo,
    output logic                               o_wdg_timeout_err
);

    // read channel
    logic             rd_req;
    lv_pkg::rac_rsp_t rd_rsp;

    lv_reg_access_ctrl rac_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr       (i_wr),
        .i_rd_req   (rd_req),
        .i_rd_addr  (o_scan_addr),
        .o_rsp      (rd_rsp)
    );

    // read address doubles as scan status
    lv_wdg_ctrl wdg_i (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_cfg             (i_cfg),
        .i_wdg_scan_en     (i_wdg_scan_en),
        .o_rd_req          (rd_req),
        .o_rd_addr         (o_scan_addr),
        .i_rsp             (rd_rsp),
        .o_scan_crc_err    (o_scan_crc_err),
        .i_bist_scan_req   (i_bist_scan_req),
        .o_bist_ack        (o_bist_ack),
        .o_bist_err        (o_bist_err),
        .i_wdg_owt_en      (i_wdg_owt_en),
        .o_owt_adc_req     (o_owt_adc_req),
        .i_owt_adc_ack     (i_owt_adc_ack),
        .i_spi_rst_wdg     (i_spi_rst_wdg),
        .i_fsm_owt_tx_req  (i_fsm_owt_tx_req),
        .i_bist_owt_tx_req (i_bist_owt_tx_req),
        .i_owt_rx_rsp      (i_owt_rx_rsp),
        .o_owt_rx_tmo      (o_owt_rx_tmo),
        .o_wdg_timeout_err (o_wdg_timeout_err)
    );

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
/*
 * testbench clock source, 4 ns period
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk
);

    localparam time HALF_PERIOD = 2ns;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// File: tests/tb_lv_wdg.sv
/*
 * lv watchdog testbench
 * register scan, bist scan and owt refresh/timeout against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lv_wdg;

    localparam logic [8:0] CRC_GEN    = 9'h107;
    localparam int         TMO_TH_20  = 20;
    localparam logic [6:0] SCAN_ORDER [6] = '{7'h01, 7'h02, 7'h03, 7'h09, 7'h0B, 7'h30};

    logic             i_clk;
    logic             i_rst_n;
    lv_pkg::reg_wr_t  i_wr;
    lv_pkg::wdg_cfg_t i_cfg;
    logic             i_wdg_scan_en;
    logic             i_bist_scan_req;
    logic [6:0]       o_scan_addr;
    logic             o_scan_crc_err;
    logic             o_bist_ack;
    logic             o_bist_err;
    logic             i_wdg_owt_en;
    logic             o_owt_adc_req;
    logic             i_owt_adc_ack;
    logic             i_spi_rst_wdg;
    logic             i_fsm_owt_tx_req;
    logic             i_bist_owt_tx_req;
    logic             i_owt_rx_rsp;
    logic             o_owt_rx_tmo;
    logic             o_wdg_timeout_err;

    // register bank as the host wrote it
    logic [7:0] model_data [128];
    logic [7:0] model_crc  [128];

    // event counters, written by the checker only
    int   ack_cnt       = 0;
    int   crc_err_cnt   = 0;
    int   adc_rise_cnt  = 0;
    int   tmo_pulse_cnt = 0;
    int   scan_idx      = 0;
    logic adc_req_prev  = 1'b0;
    logic adc_ack_prev  = 1'b0;
    logic owt_en_prev   = 1'b0;

    // owt responder control
    int   rsp_requests;
    logic rsp_answer;
    logic responder_busy;
    logic tmo_allowed;

    tb_clk_gen clk_gen_i (
        .o_clk (i_clk)
    );

    lv_wdg_top lv_wdg_top_i (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_wr              (i_wr),
        .i_cfg             (i_cfg),
        .i_wdg_scan_en     (i_wdg_scan_en),
        .i_bist_scan_req   (i_bist_scan_req),
        .o_scan_addr       (o_scan_addr),
        .o_scan_crc_err    (o_scan_crc_err),
        .o_bist_ack        (o_bist_ack),
        .o_bist_err        (o_bist_err),
        .i_wdg_owt_en      (i_wdg_owt_en),
        .o_owt_adc_req     (o_owt_adc_req),
        .i_owt_adc_ack     (i_owt_adc_ack),
        .i_spi_rst_wdg     (i_spi_rst_wdg),
        .i_fsm_owt_tx_req  (i_fsm_owt_tx_req),
        .i_bist_owt_tx_req (i_bist_owt_tx_req),
        .i_owt_rx_rsp      (i_owt_rx_rsp),
        .o_owt_rx_tmo      (o_owt_rx_tmo),
        .o_wdg_timeout_err (o_wdg_timeout_err)
    );

    // ==============================
    // reference model
    // ==============================
    // remainder of {1, addr, data} * x^8 divided by the generator
    function automatic logic [7:0] crc8_ref(input logic [6:0] addr, input logic [7:0] data);
        logic [23:0] rem;
        rem = {1'b1, addr, data, 8'h00};
        for (int i = 23; i >= 8; i--) begin
            if (rem[i]) begin
                rem = rem ^ (24'(CRC_GEN) << (i - 8));
            end
        end
        return rem[7:0];
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s (got 0x%0h, expected 0x%0h)", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: %s never happened", $time, what);
        $display("Done: errors found");
        $fatal(1, "stopping on a timeout");
    endtask

    // ==============================
    // output checker
    // ==============================
    always @(posedge i_clk) begin : check_outputs
        logic [6:0] exp_addr;
        logic       exp_err;
        if (i_rst_n) begin
            if (o_bist_ack) begin
                exp_addr = SCAN_ORDER[scan_idx];
                exp_err  = (model_crc[exp_addr] != crc8_ref(exp_addr, model_data[exp_addr]));
                check_eq(32'(o_scan_addr), 32'(exp_addr), "scan address on ack");
                check_eq(32'(o_scan_crc_err), 32'(exp_err), "crc error flag on ack");
                check_eq(32'(o_bist_err), 32'(exp_err), "bist error flag on ack");
                ack_cnt++;
                crc_err_cnt += int'(o_scan_crc_err);
                scan_idx = (scan_idx == 5) ? 0 : scan_idx + 1;
            end else begin
                check_eq(32'(o_scan_crc_err), 32'd0, "crc error without an ack");
                check_eq(32'(o_bist_err), 32'd0, "bist error without an ack");
            end
            if (o_owt_adc_req && !adc_req_prev) begin
                adc_rise_cnt++;
            end
            // a request may only end on its ack while owt is on
            if (!o_owt_adc_req && adc_req_prev && owt_en_prev) begin
                check_eq(32'(adc_ack_prev), 32'd1, "adc request dropped without ack");
            end
            tmo_pulse_cnt += int'(o_owt_rx_tmo);
            if (!tmo_allowed) begin
                check_eq(32'(o_wdg_timeout_err), 32'd0, "unexpected timeout error");
                check_eq(32'(o_owt_rx_tmo), 32'd0, "unexpected rx timeout pulse");
            end
            adc_req_prev = o_owt_adc_req;
            adc_ack_prev = i_owt_adc_ack;
            owt_en_prev  = i_wdg_owt_en;
        end
    end

    // ==============================
    // owt responder
    // ==============================
    task automatic pulse_rx_rsp();
        @(negedge i_clk);
        i_owt_rx_rsp = 1'b1;
        @(negedge i_clk);
        i_owt_rx_rsp = 1'b0;
    endtask

    initial begin : owt_responder
        int served;
        served         = 0;
        i_owt_adc_ack  = 1'b0;
        i_owt_rx_rsp   = 1'b0;
        responder_busy = 1'b0;
        forever begin
            @(posedge i_clk);
            if (rsp_requests != served) begin
                served++;
                pulse_rx_rsp();
            end else if (i_rst_n && o_owt_adc_req) begin
                responder_busy = 1'b1;
                repeat (2) @(posedge i_clk);
                @(negedge i_clk);
                i_owt_adc_ack = 1'b1;
                @(negedge i_clk);
                i_owt_adc_ack = 1'b0;
                if (rsp_answer) begin
                    pulse_rx_rsp();
                end
                responder_busy = 1'b0;
            end
        end
    end

    // ==============================
    // stimulus helpers
    // ==============================
    task automatic write_reg(input logic [6:0] addr, input logic [7:0] data,
                             input logic [7:0] crc);
        @(negedge i_clk);
        i_wr.en          = 1'b1;
        i_wr.addr        = addr;
        i_wr.data        = data;
        i_wr.crc         = crc;
        model_data[addr] = data;
        model_crc[addr]  = crc;
        @(negedge i_clk);
        i_wr.en = 1'b0;
    endtask

    // lets a read already in flight finish
    task automatic stop_scan();
        @(negedge i_clk);
        i_wdg_scan_en = 1'b0;
        repeat (6) @(negedge i_clk);
    endtask

    task automatic wait_acks(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (ack_cnt < target) begin
            @(negedge i_clk);
            n++;
            if (n > limit) report_timeout(what);
        end
    endtask

    task automatic wait_adc_rises(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (adc_rise_cnt < target) begin
            @(negedge i_clk);
            n++;
            if (n > limit) report_timeout(what);
        end
    endtask

    task automatic wait_adc_req(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (o_owt_adc_req !== level) begin
            @(negedge i_clk);
            n++;
            if (n > limit) report_timeout(what);
        end
    endtask

    task automatic wait_timeout_err(input logic level, input int limit, input string what,
                                    output int cycles);
        cycles = 0;
        while (o_wdg_timeout_err !== level) begin
            @(negedge i_clk);
            cycles++;
            if (cycles > limit) report_timeout(what);
        end
    endtask

    task automatic wait_responder_idle(input int limit);
        int n;
        n = 0;
        while (responder_busy || o_owt_adc_req) begin
            @(negedge i_clk);
            n++;
            if (n > limit) report_timeout("owt responder going idle");
        end
    endtask

    task automatic check_idle_outputs();
        check_eq(32'(o_scan_addr), 32'd0, "scan address after reset");
        check_eq(32'(o_scan_crc_err), 32'd0, "crc error after reset");
        check_eq(32'(o_bist_ack), 32'd0, "bist ack after reset");
        check_eq(32'(o_bist_err), 32'd0, "bist error after reset");
        check_eq(32'(o_owt_adc_req), 32'd0, "adc request after reset");
        check_eq(32'(o_owt_rx_tmo), 32'd0, "rx timeout after reset");
        check_eq(32'(o_wdg_timeout_err), 32'd0, "timeout error after reset");
    endtask

    // ==============================
    // test sequence
    // ==============================
    initial begin : run_tests
        int         base_ack;
        int         base_err;
        int         base_tmo;
        int         n;
        logic [7:0] data;
        void'($urandom(55230));
        i_rst_n           = 1'b0;
        i_wr              = '0;
        i_cfg             = '0;
        i_wdg_scan_en     = 1'b0;
        i_bist_scan_req   = 1'b0;
        i_wdg_owt_en      = 1'b0;
        i_spi_rst_wdg     = 1'b0;
        i_fsm_owt_tx_req  = 1'b0;
        i_bist_owt_tx_req = 1'b0;
        rsp_requests      = 0;
        rsp_answer        = 1'b1;
        tmo_allowed       = 1'b0;
        for (int a = 0; a < 128; a++) begin
            model_data[a] = 8'h00;
            model_crc[a]  = 8'h00;
        end
        repeat (4) @(negedge i_clk);
        i_rst_n = 1'b1;

        // outputs quiet out of reset
        for (int k = 0; k < 3; k++) begin
            @(negedge i_clk);
            check_idle_outputs();
        end

        // two clean scan rounds
        for (int k = 0; k < 6; k++) begin
            data = 8'($urandom());
            write_reg(SCAN_ORDER[k], data, crc8_ref(SCAN_ORDER[k], data));
        end
        base_ack = ack_cnt;
        @(negedge i_clk);
        i_wdg_scan_en = 1'b1;
        wait_acks(base_ack + 12, 400, "two clean scan rounds");
        stop_scan();

        // corrupt the stored crc of 0x09
        write_reg(7'h09, model_data[9], crc8_ref(7'h09, model_data[9]) ^ 8'h5A);
        base_ack = ack_cnt;
        base_err = crc_err_cnt;
        @(negedge i_clk);
        i_cfg.crc     = 2'd1;
        i_wdg_scan_en = 1'b1;
        wait_acks(base_ack + 12, 600, "two scan rounds with a bad crc");
        check_eq(32'(crc_err_cnt - base_err), 32'd2, "crc errors over two rounds");
        stop_scan();

        // bist scan, one read per rising edge
        for (int k = 0; k < 7; k++) begin
            base_ack = ack_cnt;
            @(negedge i_clk);
            i_bist_scan_req = 1'b1;
            wait_acks(base_ack + 1, 10, "ack for a bist scan request");
            @(negedge i_clk);
            i_bist_scan_req = 1'b0;
            repeat (3) @(negedge i_clk);
            check_eq(32'(ack_cnt - base_ack), 32'd1, "acks per bist scan request");
        end

        // owt refresh with an answering receiver
        @(negedge i_clk);
        i_cfg.refresh = 2'd0;
        i_cfg.tmo     = 2'd0;
        i_wdg_owt_en  = 1'b1;
        wait_adc_rises(adc_rise_cnt + 3, 200, "three refresh requests");
        wait_adc_req(1'b0, 20, "ack of a refresh request");
        base_ack = adc_rise_cnt;
        @(negedge i_clk);
        i_fsm_owt_tx_req = 1'b1;
        wait_adc_rises(base_ack + 1, 3, "adc request from the fsm launch");
        wait_adc_req(1'b0, 20, "ack of the fsm launched request");
        @(negedge i_clk);
        i_fsm_owt_tx_req = 1'b0;
        wait_responder_idle(20);
        check_eq(32'(adc_rise_cnt - base_ack), 32'd1, "requests from one fsm edge");

        // silent receiver, response timeout
        @(negedge i_clk);
        rsp_answer    = 1'b0;
        tmo_allowed   = 1'b1;
        i_cfg.refresh = 2'd3;
        i_cfg.tmo     = 2'd1;
        base_tmo      = tmo_pulse_cnt;
        @(negedge i_clk);
        i_bist_owt_tx_req = 1'b1;
        wait_adc_req(1'b1, 3, "adc request from the bist launch");
        wait_timeout_err(1'b1, TMO_TH_20 + 8, "timeout error", n);
        check_eq(32'(n >= TMO_TH_20 && n <= TMO_TH_20 + 4), 32'd1,
                 "timeout error outside its window");
        repeat (4) @(negedge i_clk);
        check_eq(32'(tmo_pulse_cnt - base_tmo), 32'd1, "rx timeout pulses");
        check_eq(32'(o_wdg_timeout_err), 32'd1, "timeout error held");
        i_bist_owt_tx_req = 1'b0;
        rsp_requests++;
        wait_timeout_err(1'b0, 6, "timeout error cleared by a response", n);
        repeat (3) @(negedge i_clk);
        check_eq(32'(o_wdg_timeout_err), 32'd0, "timeout error after the response");
        i_wdg_owt_en = 1'b0;
        repeat (2) @(negedge i_clk);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
src/lv_pkg.sv
src/lv_crc8.sv
src/lv_reg_access_ctrl.sv
src/lv_wdg_ctrl.sv
src/lv_wdg_top.sv
tests/tb_clk_gen.sv
tests/tb_lv_wdg.sv

// File: run.sh
#!/bin/sh
# build the watchdog testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_lv_wdg \
    -f src.f -o sim_tb_lv_wdg
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_lv_wdg 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
